// ==== logic/record_arbiter.sv ====
`timescale 1ns/10ps

module record_arbiter #(
  parameter int n_channels = 4,
  localparam int chan_w = tdc_pkg::chan_bits(n_channels)
) (
  input  logic                                  clk,
  input  logic                                  rst,
  input  logic [n_channels-1:0]                 wr_en,
  input  tdc_pkg::tdc_record_t [n_channels-1:0] chan_record,
  output logic [n_channels-1:0]                 done,
  output logic                                  record_valid,
  output tdc_pkg::tdc_record_t                  record,
  output logic [chan_w-1:0]                     record_chan
);

  logic [n_channels-1:0] req;
  logic [chan_w-1:0]     ptr_q;   // channel with top priority
  logic [chan_w-1:0]     pick;
  logic                  hit;

  // done doubles as last grant mask, that channel still has wr_en up
  assign req = wr_en & ~done;

  // scan from ptr_q, nearest requester wins
  always_comb begin
    int idx;
    hit  = 1'b0;
    pick = ptr_q;
    for (int i = n_channels - 1; i >= 0; i--) begin
      idx = (int'(ptr_q) + i) % n_channels;
      if (req[idx]) begin
        hit  = 1'b1;
        pick = chan_w'(idx);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      record_valid <= 1'b0;
      done         <= '0;
      ptr_q        <= '0;
    end else begin
      record_valid <= hit;
      done         <= '0;
      if (hit) begin
        done[pick] <= 1'b1;
        ptr_q      <= (pick == chan_w'(n_channels - 1)) ? '0 : pick + 1'b1;
      end
    end
  end

  // payload, no reset
  always_ff @(posedge clk) begin
    if (hit) begin
      record      <= chan_record[pick];
      record_chan <= pick;
    end
  end

  assert property (@(posedge clk) disable iff (rst) $onehot0(done))
    else $error("more than one done");

  // controller must still hold its request when done arrives
  assert property (@(posedge clk) disable iff (rst) (done & ~wr_en) == '0)
    else $error("done to a channel without wr_en");

endmodule

// ==== logic/shot_scheduler.sv ====
`timescale 1ns/10ps

module shot_scheduler #(
  parameter logic [31:0] shot_period = 32'd2000  // cycles between shots
) (
  input  logic clk,
  input  logic rst,
  input  logic play,
  input  logic pause,
  output logic run,
  output logic shot_tick
);

  localparam logic [31:0] period_last = shot_period - 32'd1;

  logic [31:0] cnt_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      run       <= 1'b0;
      shot_tick <= 1'b0;
      cnt_q     <= '0;
    end else begin
      shot_tick <= 1'b0;
      if (pause) begin
        run   <= 1'b0;
        cnt_q <= '0;
      end else if (play) begin
        run   <= 1'b1;
        cnt_q <= '0;  // every play restarts the phase, channels stay in step
      end else if (run) begin
        if (cnt_q == period_last) begin
          cnt_q     <= '0;
          shot_tick <= 1'b1;
        end else begin
          cnt_q <= cnt_q + 1'b1;
        end
      end
    end
  end

  assert property (@(posedge clk) disable iff (rst) shot_tick |-> run)
    else $error("shot_tick while stopped");

endmodule

// ==== logic/spi_byte_master.sv ====
`timescale 1ns/10ps

module spi_byte_master #(
  parameter int spi_div = 2  // system clocks per half sclk
) (
  input  logic               clk,
  input  logic               rst,
  input  logic               start,
  input  logic               cs_end,
  input  tdc_pkg::spi_byte_t tx_byte,
  input  logic               miso,
  output logic               busy,
  output tdc_pkg::spi_byte_t rx_byte,
  output logic               sclk,
  output logic               mosi,
  output logic               cs_n
);
  import tdc_pkg::*;

  localparam int div_w = (spi_div > 1) ? $clog2(spi_div) : 1;
  localparam logic [div_w-1:0] div_last = div_w'(spi_div - 1);

  logic [div_w-1:0] div_q;    // half period counter
  logic [2:0]       bit_q;    // falling edges seen
  logic             last_q;   // close frame after this byte
  logic             miso_q;   // bit caught on rising sclk
  spi_byte_t        sr_q;     // tx out at the top, rx in at the bottom

  assign rx_byte = sr_q;  // stable until the next start reloads it
  assign mosi = busy ? sr_q[7] : 1'b0;

  always_ff @(posedge clk) begin
    if (rst) begin
      busy   <= 1'b0;
      sclk   <= 1'b0;
      cs_n   <= 1'b1;
      last_q <= 1'b0;
      div_q  <= '0;
      bit_q  <= '0;
    end else if (!busy) begin
      if (start) begin
        busy   <= 1'b1;
        cs_n   <= 1'b0;     // stays low if frame already open
        last_q <= cs_end;
        div_q  <= '0;
        bit_q  <= '0;
        sclk   <= 1'b0;
      end
    end else if (div_q == div_last) begin
      div_q <= '0;
      if (!sclk) begin
        sclk <= 1'b1;       // rising edge, slave samples mosi
      end else begin
        sclk <= 1'b0;
        if (bit_q == 3'd7) begin
          busy <= 1'b0;
          if (last_q) cs_n <= 1'b1;
        end else begin
          bit_q <= bit_q + 1'b1;
        end
      end
    end else begin
      div_q <= div_q + 1'b1;
    end
  end

  // data path, no reset
  always_ff @(posedge clk) begin
    if (!busy && start) begin
      sr_q <= tx_byte;
    end else if (busy && div_q == div_last) begin
      if (!sclk) miso_q <= miso;                  // mode 0 sample point
      else sr_q <= {sr_q[6:0], miso_q};           // next bit out, caught bit in
    end
  end

endmodule

// ==== logic/tdc_array_top.sv ====
`timescale 1ns/10ps

module tdc_array_top #(
  parameter int          n_channels  = 4,
  parameter logic [31:0] shot_period = 32'd2000,
  parameter int          spi_div     = 2,
  parameter int          start_wait  = 5,
  parameter int          start_width = 3,
  localparam int chan_w = tdc_pkg::chan_bits(n_channels)
) (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  soft_reset,
  input  logic                  play,
  input  logic                  pause,
  input  logic [n_channels-1:0] miso,
  input  logic [n_channels-1:0] intb_n,
  output logic [n_channels-1:0] sclk,
  output logic [n_channels-1:0] mosi,
  output logic [n_channels-1:0] cs_n,
  output logic [n_channels-1:0] start_pulse,
  output logic                  record_valid,
  output tdc_pkg::tdc_record_t  record,
  output logic [chan_w-1:0]     record_chan
);
  import tdc_pkg::*;

  logic run;
  logic shot_tick;

  // per channel, indexed by channel number
  logic [n_channels-1:0]        spi_start;
  logic [n_channels-1:0]        cs_end;
  logic [n_channels-1:0]        busy;
  logic [n_channels-1:0]        wr_en;
  logic [n_channels-1:0]        done;
  spi_byte_t [n_channels-1:0]   tx_byte;
  spi_byte_t [n_channels-1:0]   rx_byte;
  tdc_record_t [n_channels-1:0] chan_record;

  shot_scheduler #(
    .shot_period (shot_period)
  ) shot_scheduler_i (
    .clk       (clk),
    .rst       (rst),
    .play      (play),
    .pause     (pause),
    .run       (run),
    .shot_tick (shot_tick)
  );

  for (genvar ch = 0; ch < n_channels; ch++) begin : g_chan
    tdc_control #(
      .start_wait  (start_wait),
      .start_width (start_width)
    ) tdc_control_i (
      .clk         (clk),
      .rst         (rst),
      .soft_reset  (soft_reset),
      .run         (run),
      .pause       (pause),
      .shot_tick   (shot_tick),
      .busy        (busy[ch]),
      .rx_byte     (rx_byte[ch]),
      .intb_n      (intb_n[ch]),
      .done        (done[ch]),
      .spi_start   (spi_start[ch]),
      .cs_end      (cs_end[ch]),
      .tx_byte     (tx_byte[ch]),
      .start_pulse (start_pulse[ch]),
      .wr_en       (wr_en[ch]),
      .record      (chan_record[ch])
    );

    spi_byte_master #(
      .spi_div (spi_div)
    ) spi_byte_master_i (
      .clk     (clk),
      .rst     (rst),
      .start   (spi_start[ch]),
      .cs_end  (cs_end[ch]),
      .tx_byte (tx_byte[ch]),
      .miso    (miso[ch]),
      .busy    (busy[ch]),
      .rx_byte (rx_byte[ch]),
      .sclk    (sclk[ch]),
      .mosi    (mosi[ch]),
      .cs_n    (cs_n[ch])
    );
  end

  record_arbiter #(
    .n_channels (n_channels)
  ) record_arbiter_i (
    .clk          (clk),
    .rst          (rst),
    .wr_en        (wr_en),
    .chan_record  (chan_record),
    .done         (done),
    .record_valid (record_valid),
    .record       (record),
    .record_chan  (record_chan)
  );

endmodule

// ==== logic/tdc_control.sv ====
`timescale 1ns/10ps

module tdc_control #(
  parameter int start_wait  = 5,   // cycles from last trigger byte to start
  parameter int start_width = 3    // start pulse length
) (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 soft_reset,
  input  logic                 run,
  input  logic                 pause,
  input  logic                 shot_tick,
  input  logic                 busy,
  input  tdc_pkg::spi_byte_t   rx_byte,
  input  logic                 intb_n,
  input  logic                 done,
  output logic                 spi_start,
  output logic                 cs_end,
  output tdc_pkg::spi_byte_t   tx_byte,
  output logic                 start_pulse,
  output logic                 wr_en,
  output tdc_pkg::tdc_record_t record
);
  import tdc_pkg::*;

  localparam logic [15:0] wait_last  = 16'(start_wait - 1);
  localparam logic [15:0] width_last = 16'(start_width - 1);
  localparam rom_addr_t   read_last  = calib2_first_addr + 6'd3;

  typedef enum logic [3:0] {
    st_idle,
    st_config,     // nine write pairs
    st_delay,      // waiting for a shot
    st_trig,
    st_trig_wait,
    st_start,
    st_intb_wait,
    st_read,
    st_hand_off    // record out, wait for done
  } state_t;

  state_t      state_q;
  rom_addr_t   addr_q;
  logic        launch_q;      // start the byte at addr_q once rom output settled
  logic [15:0] cnt_q;
  logic [1:0]  intb_sync_q;
  tdc_record_t rec_q;
  logic        link_free;
  logic        read_step;

  tdc_rom tdc_rom_i (
    .clk  (clk),
    .addr (addr_q),
    .data (tx_byte)
  );

  // last byte of a frame: pairs below the readout, blocks of four above
  function automatic logic frame_end(rom_addr_t a);
    return (a < time1_first_addr) ? a[0] : (a[1:0] == 2'b11);
  endfunction

  // byte at addr_q finished, rx_byte belongs to it
  assign link_free = !busy && !spi_start && !launch_q;
  assign read_step = (state_q == st_read) && link_free;
  assign record = rec_q;

  always_ff @(posedge clk) begin
    if (rst) intb_sync_q <= 2'b11;
    else intb_sync_q <= {intb_sync_q[0], intb_n};  // chip pin is async
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q     <= st_idle;
      addr_q      <= '0;
      launch_q    <= 1'b0;
      spi_start   <= 1'b0;
      cs_end      <= 1'b0;
      cnt_q       <= '0;
      start_pulse <= 1'b0;
    end else if (pause) begin
      state_q     <= st_idle;
      launch_q    <= 1'b0;
      spi_start   <= 1'b0;
      start_pulse <= 1'b0;
    end else begin
      spi_start <= 1'b0;
      if (launch_q && !busy) begin
        spi_start <= 1'b1;  // rom data for addr_q is on tx_byte now
        cs_end    <= frame_end(addr_q);
        launch_q  <= 1'b0;
      end
      case (state_q)
        st_idle: begin
          if (soft_reset) begin
            addr_q   <= '0;
            launch_q <= 1'b1;
            state_q  <= st_config;
          end else if (run) begin
            state_q <= st_delay;  // resume, chip keeps its config
          end
        end
        st_config: begin
          if (link_free) begin
            if (addr_q == cfg_last_addr) begin
              state_q <= st_delay;
            end else begin
              addr_q   <= addr_q + 1'b1;
              launch_q <= 1'b1;
            end
          end
        end
        st_delay: begin
          if (soft_reset) begin
            addr_q   <= '0;
            launch_q <= 1'b1;
            state_q  <= st_config;
          end else if (run && shot_tick && !wr_en) begin  // no shot while a record waits
            addr_q   <= trig_first_addr;
            launch_q <= 1'b1;
            state_q  <= st_trig;
          end
        end
        st_trig: begin
          if (link_free) begin
            if (addr_q == trig_last_addr) begin
              cnt_q   <= '0;
              state_q <= st_trig_wait;
            end else begin
              addr_q   <= addr_q + 1'b1;
              launch_q <= 1'b1;
            end
          end
        end
        st_trig_wait: begin
          if (cnt_q == wait_last) begin
            cnt_q       <= '0;
            start_pulse <= 1'b1;
            state_q     <= st_start;
          end else begin
            cnt_q <= cnt_q + 1'b1;
          end
        end
        st_start: begin
          if (cnt_q == width_last) begin
            start_pulse <= 1'b0;
            state_q     <= st_intb_wait;
          end else begin
            cnt_q <= cnt_q + 1'b1;
          end
        end
        st_intb_wait: begin
          if (!intb_sync_q[1]) begin  // measurement ready
            addr_q   <= time1_first_addr;
            launch_q <= 1'b1;
            state_q  <= st_read;
          end
        end
        st_read: begin
          if (link_free) begin
            if (addr_q == read_last) begin
              state_q <= st_hand_off;
            end else begin
              addr_q   <= addr_q + 1'b1;
              launch_q <= 1'b1;
            end
          end
        end
        st_hand_off: if (done) state_q <= st_delay;
        default: state_q <= st_idle;
      endcase
    end
  end

  // held through a pause so an in-flight record still drains
  always_ff @(posedge clk) begin
    if (rst) wr_en <= 1'b0;
    else if (done) wr_en <= 1'b0;
    else if (!pause && read_step && addr_q == read_last) wr_en <= 1'b1;
  end

  // blocks are 4-aligned, so addr bit 1 marks the 3rd and 4th byte
  always_ff @(posedge clk) begin
    if (read_step && addr_q[1]) begin
      if (addr_q < calib1_first_addr) rec_q.time1 <= {rec_q.time1[7:0], rx_byte};
      else if (addr_q < calib2_first_addr) rec_q.calib1 <= {rec_q.calib1[7:0], rx_byte};
      else rec_q.calib2 <= {rec_q.calib2[7:0], rx_byte};
    end
  end

  // link protocol with the byte master
  assert property (@(posedge clk) disable iff (rst) spi_start |-> !busy)
    else $error("spi_start while link busy");

  // record must not move under the arbiter
  assert property (@(posedge clk) disable iff (rst)
    wr_en && !done |=> wr_en && $stable(record))
    else $error("wr_en or record changed before done");

endmodule

// ==== logic/tdc_pkg.sv ====
package tdc_pkg;

  typedef logic [7:0] spi_byte_t;   // one byte on the chip link
  typedef logic [5:0] rom_addr_t;   // command rom index
  typedef logic [15:0] tdc_word_t;  // low half of a 24-bit result register

  // one measurement, time1 in the low bits
  typedef struct packed {
    tdc_word_t calib2;
    tdc_word_t calib1;
    tdc_word_t time1;
  } tdc_record_t;

  // rom map
  localparam rom_addr_t cfg_last_addr     = 6'd17;  // 0..17 are nine write pairs
  localparam rom_addr_t trig_first_addr   = 6'd18;
  localparam rom_addr_t trig_last_addr    = 6'd19;
  localparam rom_addr_t time1_first_addr  = 6'd20;  // read blocks are 4 bytes each
  localparam rom_addr_t calib1_first_addr = 6'd24;
  localparam rom_addr_t calib2_first_addr = 6'd28;

  // chip commands: write is flag | reg, read is the bare reg
  localparam spi_byte_t cmd_write = 8'h40;

  localparam spi_byte_t reg_config1        = 8'h00;
  localparam spi_byte_t reg_config2        = 8'h01;
  localparam spi_byte_t reg_int_status     = 8'h02;
  localparam spi_byte_t reg_int_mask       = 8'h03;
  localparam spi_byte_t reg_coarse_ovf_h   = 8'h04;
  localparam spi_byte_t reg_coarse_ovf_l   = 8'h05;
  localparam spi_byte_t reg_clock_ovf_h    = 8'h06;
  localparam spi_byte_t reg_clock_ovf_l    = 8'h07;
  localparam spi_byte_t reg_clock_stop_h   = 8'h08;
  localparam spi_byte_t reg_time1          = 8'h10;
  localparam spi_byte_t reg_calib1         = 8'h1B;
  localparam spi_byte_t reg_calib2         = 8'h1C;

  localparam spi_byte_t cfg1_meas_mode2  = 8'h02;  // measurement mode 2
  localparam spi_byte_t cfg1_start_meas  = 8'h01;  // start bit, self clearing on chip

  // width of a channel number, at least one bit
  function automatic int chan_bits(int n);
    return (n > 1) ? $clog2(n) : 1;
  endfunction

endpackage

// ==== logic/tdc_rom.sv ====
`timescale 1ns/10ps

module tdc_rom (
  input  logic               clk,
  input  tdc_pkg::rom_addr_t addr,
  output tdc_pkg::spi_byte_t data
);
  import tdc_pkg::*;

  // one cycle read latency, no reset on the data
  always_ff @(posedge clk) begin
    case (addr)
      // configuration, nine write pairs
      6'd0:  data <= cmd_write | reg_config1;
      6'd1:  data <= cfg1_meas_mode2;
      6'd2:  data <= cmd_write | reg_config2;
      6'd3:  data <= 8'h40;  // 10 calib periods, no averaging, single stop
      6'd4:  data <= cmd_write | reg_int_status;
      6'd5:  data <= 8'h1F;  // clear all flags
      6'd6:  data <= cmd_write | reg_int_mask;
      6'd7:  data <= 8'h07;  // all interrupts on
      6'd8:  data <= cmd_write | reg_coarse_ovf_h;
      6'd9:  data <= 8'hFF;
      6'd10: data <= cmd_write | reg_coarse_ovf_l;
      6'd11: data <= 8'hFF;
      6'd12: data <= cmd_write | reg_clock_ovf_h;
      6'd13: data <= 8'hFF;
      6'd14: data <= cmd_write | reg_clock_ovf_l;
      6'd15: data <= 8'hFF;
      6'd16: data <= cmd_write | reg_clock_stop_h;
      6'd17: data <= 8'h00;
      // trigger, config1 with the start bit
      6'd18: data <= cmd_write | reg_config1;
      6'd19: data <= cfg1_meas_mode2 | cfg1_start_meas;
      // readout, command then three dummies
      6'd20: data <= reg_time1;
      6'd21: data <= 8'h00;
      6'd22: data <= 8'h00;
      6'd23: data <= 8'h00;
      6'd24: data <= reg_calib1;
      6'd25: data <= 8'h00;
      6'd26: data <= 8'h00;
      6'd27: data <= 8'h00;
      6'd28: data <= reg_calib2;
      6'd29: data <= 8'h00;
      6'd30: data <= 8'h00;
      6'd31: data <= 8'h00;
      default: data <= 8'h00;  // upper half unused
    endcase
  end

endmodule

// ==== sources.f ====
logic/tdc_pkg.sv
logic/tdc_rom.sv
logic/spi_byte_master.sv
logic/tdc_control.sv
logic/shot_scheduler.sv
logic/record_arbiter.sv
logic/tdc_array_top.sv
test/tdc_chip_model.sv
test/tb_tdc_array.sv

// ==== test/tb_tdc_array.sv ====
`timescale 1ns/10ps

module tb_tdc_array;
  import tdc_pkg::*;

  localparam int          n_channels  = 4;
  localparam logic [31:0] shot_period = 32'd1000;
  localparam int          start_width = 3;
  localparam int          chan_w      = tdc_pkg::chan_bits(n_channels);

  logic clk, rst, soft_reset, play, pause;
  logic [n_channels-1:0] miso, intb_n, sclk, mosi, cs_n, start_pulse;
  logic                  record_valid;
  tdc_record_t           record;
  logic [chan_w-1:0]     record_chan;
  int n_writes[n_channels];
  int bad_frames[n_channels];

  logic [23:0] t1_a[n_channels], c1_a[n_channels], c2_a[n_channels];
  int          dly_a[n_channels];
  tdc_record_t exp_rec[n_channels];
  tdc_record_t got_rec[$];
  logic [chan_w-1:0] got_chan[$];
  int          got_cyc[$];
  int          hi_cnt[n_channels];
  int          cyc, errors, checks, tests, failed_tests;
  event        load_ev, clear_ev, cfg_check_ev, trig_check_ev;

  // nine configuration pairs as address byte then data byte
  spi_byte_t exp_cfg[18] = '{8'h40, 8'h02, 8'h41, 8'h40, 8'h42, 8'h1F, 8'h43, 8'h07,
    8'h44, 8'hFF, 8'h45, 8'hFF, 8'h46, 8'hFF, 8'h47, 8'hFF, 8'h48, 8'h00};

  tdc_array_top #(.n_channels(n_channels), .shot_period(shot_period), .spi_div(2),
    .start_wait(5), .start_width(start_width)) tdc_array_top_i (
    .clk(clk), .rst(rst), .soft_reset(soft_reset), .play(play), .pause(pause),
    .miso(miso), .intb_n(intb_n), .sclk(sclk), .mosi(mosi), .cs_n(cs_n),
    .start_pulse(start_pulse), .record_valid(record_valid), .record(record),
    .record_chan(record_chan)
  );

  for (genvar ch = 0; ch < n_channels; ch++) begin : g_chip
    tdc_chip_model chip_i (
      .clk(clk), .sclk(sclk[ch]), .mosi(mosi[ch]), .cs_n(cs_n[ch]),
      .start_pulse(start_pulse[ch]), .miso(miso[ch]), .intb_n(intb_n[ch]),
      .n_writes(n_writes[ch]), .bad_frames(bad_frames[ch])
    );
    always @(load_ev) chip_i.load_values(t1_a[ch], c1_a[ch], c2_a[ch], dly_a[ch]);
    always @(clear_ev) chip_i.clear_log();
    always @(cfg_check_ev) begin
      check_count(n_writes[ch], 9, $sformatf("ch%0d config writes", ch));
      check_count(bad_frames[ch], 0, $sformatf("ch%0d bad frames", ch));
      for (int i = 0; i < 9 && i < chip_i.wr_addr.size(); i++) begin
        check_byte(chip_i.wr_addr[i], exp_cfg[2*i], $sformatf("ch%0d cfg addr %0d", ch, i));
        check_byte(chip_i.wr_data[i], exp_cfg[2*i+1], $sformatf("ch%0d cfg data %0d", ch, i));
      end
    end
    always @(trig_check_ev) begin  // only the trigger pair after resume
      check_count(n_writes[ch], 1, $sformatf("ch%0d writes after resume", ch));
      for (int i = 0; i < chip_i.wr_addr.size(); i++) begin
        check_byte(chip_i.wr_addr[i], 8'h40, $sformatf("ch%0d resume addr", ch));
        check_byte(chip_i.wr_data[i], 8'h03, $sformatf("ch%0d resume data", ch));
      end
    end
  end

  always #10 clk = ~clk;
  always @(posedge clk) cyc <= cyc + 1;

  // sample away from the active edge
  always @(negedge clk) begin
    if (!rst && record_valid) begin
      got_rec.push_back(record);
      got_chan.push_back(record_chan);
      got_cyc.push_back(cyc);
    end
    for (int ch = 0; ch < n_channels; ch++) begin
      if (start_pulse[ch] === 1'b1) hi_cnt[ch]++;
      else if (hi_cnt[ch] != 0) begin
        check_count(hi_cnt[ch], start_width, $sformatf("ch%0d start width", ch));
        hi_cnt[ch] = 0;
      end
    end
  end

  task automatic report(string what, logic ok_cond, string detail);
    checks++;
    if (!ok_cond) begin
      $display("CHECK FAILED @%0t: %s %s", $time, what, detail);
      errors++;
    end
  endtask

  task automatic check_record(tdc_record_t got, tdc_record_t exp, string what);
    report(what, got === exp, $sformatf("got %h exp %h", got, exp));
  endtask

  task automatic check_chan(logic [chan_w-1:0] got, logic [chan_w-1:0] exp, string what);
    report(what, got === exp, $sformatf("got %0d exp %0d", got, exp));
  endtask

  task automatic check_byte(spi_byte_t got, spi_byte_t exp, string what);
    report(what, got === exp, $sformatf("got %h exp %h", got, exp));
  endtask

  task automatic check_count(int got, int exp, string what);
    report(what, got == exp, $sformatf("got %0d exp %0d", got, exp));
  endtask

  task automatic give_up(string what);
    $display("timeout while waiting for %s", what);
    $display("TESTS FAILED");
    $finish;
  endtask

  task automatic pulse(ref logic sig);
    @(negedge clk) sig = 1'b1;
    @(negedge clk) sig = 1'b0;
  endtask

  task automatic finish_test(string name, int err_before);
    tests++;
    if (errors != err_before) failed_tests++;
    $display("%s: %s", name, (errors == err_before) ? "ok" : "failed");
  endtask

  // fresh random values for every chip, a shared delay when same_delay >= 0
  task automatic load_chips(int same_delay);
    for (int ch = 0; ch < n_channels; ch++) begin
      t1_a[ch]  = 24'($urandom);
      c1_a[ch]  = 24'($urandom);
      c2_a[ch]  = 24'($urandom);
      dly_a[ch] = (same_delay >= 0) ? same_delay : int'($urandom % 20);
      exp_rec[ch] = {c2_a[ch][15:0], c1_a[ch][15:0], t1_a[ch][15:0]};
    end
    -> load_ev;
    @(posedge clk);
  endtask

  task automatic collect_shot(string tag, bit back_to_back);
    int t;
    int idx;
    t = 0;
    while (got_rec.size() < n_channels) begin
      @(negedge clk);
      if (++t > 3 * shot_period) give_up({tag, " records"});
    end
    repeat (50) @(negedge clk);  // nothing extra may follow
    check_count(got_rec.size(), n_channels, {tag, " record count"});
    if (back_to_back) begin  // one grant per cycle while all channels wait
      for (int k = 1; k < got_cyc.size(); k++)
        report({tag, " strobe spacing"}, got_cyc[k] == got_cyc[k-1] + 1,
          "contended records not in consecutive cycles");
    end
    for (int ch = 0; ch < n_channels; ch++) begin
      idx = -1;
      foreach (got_rec[k]) if (got_rec[k] === exp_rec[ch]) idx = k;
      if (idx < 0) begin
        check_record(got_rec.size() > 0 ? got_rec[0] : '0, exp_rec[ch],
          $sformatf("%s ch%0d record missing", tag, ch));
      end else begin
        check_chan(got_chan[idx], chan_w'(ch), $sformatf("%s ch%0d tag", tag, ch));
      end
    end
    got_rec.delete();
    got_chan.delete();
    got_cyc.delete();
  endtask

  task automatic test_idle();
    int e;
    e = errors;
    repeat (40) begin
      @(negedge clk);
      report("idle", record_valid === 1'b0 && start_pulse === '0 && cs_n === '1,
        "outputs not idle");
    end
    finish_test("idle after reset", e);
  endtask

  task automatic test_config();
    int e;
    int t;
    e = errors;
    pulse(soft_reset);
    t = 0;
    for (int ch = 0; ch < n_channels; ch++) begin
      while (n_writes[ch] < 9 || cs_n != '1) begin
        @(negedge clk);
        if (++t > 5000) give_up("configuration writes");
      end
    end
    repeat (20) @(negedge clk);
    -> cfg_check_ev;
    @(posedge clk);
    finish_test("configuration", e);
  endtask

  task automatic test_shots(string name, int same_delay, int n_shots);
    int e;
    e = errors;
    for (int s = 0; s < n_shots; s++) begin
      load_chips(same_delay);
      collect_shot($sformatf("%s shot %0d", name, s), same_delay >= 0);
    end
    finish_test(name, e);
  endtask

  task automatic test_pause();
    int e;
    e = errors;
    pulse(pause);
    repeat (shot_period) @(negedge clk);  // drain in-flight records
    got_rec.delete();
    got_chan.delete();
    got_cyc.delete();
    repeat (2 * shot_period) @(negedge clk);
    check_count(got_rec.size(), 0, "records while paused");
    -> clear_ev;
    load_chips(-1);
    pulse(play);
    collect_shot("resume", 1'b0);
    -> trig_check_ev;
    @(posedge clk);
    finish_test("pause and resume", e);
  endtask

  initial begin
    void'($urandom(32'h8176));
    clk          = 1'b0;
    rst          = 1'b1;
    soft_reset   = 1'b0;
    play         = 1'b0;
    pause        = 1'b0;
    cyc          = 0;
    errors       = 0;
    checks       = 0;
    tests        = 0;
    failed_tests = 0;
    foreach (hi_cnt[ch]) hi_cnt[ch] = 0;
    repeat (4) @(negedge clk);
    rst = 1'b0;
    test_idle();
    test_config();
    pulse(play);
    test_shots("play", -1, 2);
    test_shots("contention", 0, 2);
    test_shots("fresh values", -1, 3);
    test_pause();
    $display("tests %0d, failed %0d, checks %0d, errors %0d",
      tests, failed_tests, checks, errors);
    if (errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

// ==== test/tdc_chip_model.sv ====
`timescale 1ns/10ps

module tdc_chip_model (
  input  logic clk,
  input  logic sclk,
  input  logic mosi,
  input  logic cs_n,
  input  logic start_pulse,
  output logic miso,
  output logic intb_n,
  output int   n_writes,    // write pairs seen so far
  output int   bad_frames   // frames of the wrong length
);
  import tdc_pkg::*;

  logic [23:0] time1_v;
  logic [23:0] calib1_v;
  logic [23:0] calib2_v;
  logic [23:0] out_v;       // register being read out
  int          int_delay;   // clocks from start fall to intb low
  int          nbits;       // bits in the current frame
  int          wait_cnt;
  logic        armed;
  logic        counting;
  spi_byte_t   sr;
  spi_byte_t   cmd;
  spi_byte_t   wr_addr[$];  // write log with one entry per pair
  spi_byte_t   wr_data[$];

  task automatic load_values(logic [23:0] t1, logic [23:0] c1, logic [23:0] c2, int dly);
    time1_v   = t1;
    calib1_v  = c1;
    calib2_v  = c2;
    int_delay = dly;
  endtask

  task automatic clear_log();
    wr_addr.delete();
    wr_data.delete();
    n_writes = 0;
  endtask

  initial begin
    intb_n     = 1'b1;
    nbits      = 0;
    n_writes   = 0;
    bad_frames = 0;
    armed      = 1'b0;
    counting   = 1'b0;
    wait_cnt   = 0;
    cmd        = 8'h00;
    time1_v    = '0;
    calib1_v   = '0;
    calib2_v   = '0;
    int_delay  = 0;
    out_v      = '0;
  end

  always @(negedge cs_n) nbits = 0;  // new frame

  // mode 0 slave takes mosi on rising sclk
  always @(posedge sclk) begin
    if (!cs_n) begin
      sr = {sr[6:0], mosi};
      nbits++;
      if (nbits == 8) begin
        cmd = sr;
        if (!cmd[6]) begin
          intb_n = 1'b1;  // first read clears the interrupt
          case (cmd)
            reg_time1:  out_v = time1_v;
            reg_calib1: out_v = calib1_v;
            reg_calib2: out_v = calib2_v;
            default:    out_v = '0;
          endcase
        end
      end else if (nbits == 16 && cmd[6]) begin
        wr_addr.push_back(cmd);
        wr_data.push_back(sr);
        n_writes++;
        if (cmd[5:0] == 6'd0 && sr[0]) armed = 1'b1;  // start measurement
      end
    end
  end

  // data bits follow the command byte msb first
  always_comb begin
    if (!cs_n && !cmd[6] && nbits >= 8 && nbits < 32) miso = out_v[31 - nbits];
    else miso = 1'b0;
  end

  always @(posedge cs_n) begin
    if (nbits != 0 && nbits != (cmd[6] ? 16 : 32)) bad_frames++;
    nbits = 0;
  end

  always @(negedge start_pulse) begin
    if (armed) begin
      armed    = 1'b0;
      counting = 1'b1;
      wait_cnt = int_delay;
    end
  end

  always @(negedge clk) begin
    if (counting) begin
      if (wait_cnt == 0) begin
        intb_n   = 1'b0;
        counting = 1'b0;
      end else wait_cnt--;
    end
  end

endmodule
